// File: test/exePatterns.txt
// op_useImm_noGap_flush_rs_rt_dst_shamt_srcA_srcB_imm_wbWr_wbDst_wbData
// then expected: resWr_branchTaken_overflowExc_resDst_resData
01_0_0_0_01_02_03_00_00000005_00000007_00000000_0_00_00000000_1_0_0_03_0000000c
02_1_0_0_01_00_04_00_7fffffff_00000000_00000001_0_00_00000000_1_0_0_04_80000000
03_0_0_0_01_02_05_00_00000010_00000003_00000000_0_00_00000000_1_0_0_05_0000000d
04_0_0_0_01_02_06_00_00000000_00000001_00000000_0_00_00000000_1_0_0_06_ffffffff
05_0_0_0_01_02_07_00_f0f0ff00_ff00f0f0_00000000_0_00_00000000_1_0_0_07_f000f000
06_0_0_0_01_02_08_00_f0f00000_0000000f_00000000_0_00_00000000_1_0_0_08_f0f0000f
07_0_0_0_01_02_09_00_aaaa5555_ffff0000_00000000_0_00_00000000_1_0_0_09_55555555
08_0_0_0_01_02_0a_00_0000ffff_00ff0000_00000000_0_00_00000000_1_0_0_0a_ff000000
09_0_0_0_01_02_0b_00_ffffffff_00000001_00000000_0_00_00000000_1_0_0_0b_00000001
0a_0_0_0_01_02_0c_00_ffffffff_00000001_00000000_0_00_00000000_1_0_0_0c_00000000
0b_0_0_0_00_02_0d_04_00000000_0000000f_00000000_0_00_00000000_1_0_0_0d_000000f0
0c_0_0_0_00_02_0e_08_00000000_80000000_00000000_0_00_00000000_1_0_0_0e_00800000
0d_0_0_0_00_02_0f_08_00000000_80000000_00000000_0_00_00000000_1_0_0_0f_ff800000
0e_1_0_0_00_00_10_00_00000000_00000000_00001234_0_00_00000000_1_0_0_10_12340000
02_0_0_0_01_02_11_00_00000100_00000001_00000000_0_00_00000000_1_0_0_11_00000101
02_0_1_0_11_02_12_00_00000000_00000002_00000000_1_11_deadbeef_1_0_0_12_00000103
04_0_1_0_12_05_13_00_00000000_00000000_00000000_1_05_00000003_1_0_0_13_00000100
06_0_1_0_00_13_14_00_00000000_00000000_00000000_1_00_ffffffff_1_0_0_14_00000100
0f_0_1_0_14_02_00_00_00000000_00000100_00000000_0_00_00000000_0_1_0_00_00000000
10_0_0_0_01_02_00_00_00000005_00000005_00000000_0_00_00000000_0_0_0_00_00000000
01_0_0_0_01_02_15_00_7fffffff_00000001_00000000_0_00_00000000_0_0_1_15_00000000
03_0_0_0_01_02_16_00_80000000_00000001_00000000_0_00_00000000_0_0_1_16_00000000
04_0_0_0_01_02_17_00_80000000_00000001_00000000_0_00_00000000_1_0_0_17_7fffffff
11_0_0_0_01_02_00_00_fffffffd_00000007_00000000_0_00_00000000_0_0_0_00_00000000
15_0_0_0_00_00_18_00_00000000_00000000_00000000_0_00_00000000_1_0_0_18_ffffffff
16_0_0_0_00_00_19_00_00000000_00000000_00000000_0_00_00000000_1_0_0_19_ffffffeb
12_0_0_0_01_02_00_00_ffffffff_00000002_00000000_0_00_00000000_0_0_0_00_00000000
15_0_0_0_00_00_1a_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1a_00000001
13_0_0_0_01_02_00_00_ffffffe9_00000005_00000000_0_00_00000000_0_0_0_00_00000000
16_0_0_0_00_00_1b_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1b_fffffffc
15_0_0_0_00_00_1c_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1c_fffffffd
14_0_0_0_01_02_00_00_00001234_00000000_00000000_0_00_00000000_0_0_0_00_00000000
15_0_0_0_00_00_1d_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1d_00001234
16_0_0_0_00_00_1e_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1e_ffffffff
17_0_0_0_01_00_00_00_12345678_00000000_00000000_0_00_00000000_0_0_0_00_00000000
18_0_0_0_01_00_00_00_9abcdef0_00000000_00000000_0_00_00000000_0_0_0_00_00000000
15_0_1_0_00_00_1f_00_00000000_00000000_00000000_0_00_00000000_1_0_0_1f_12345678
16_0_1_0_00_00_01_00_00000000_00000000_00000000_0_00_00000000_1_0_0_01_9abcdef0
13_0_0_1_01_02_00_00_00000064_00000007_00000000_0_00_00000000_0_0_0_00_00000000
15_0_0_0_00_00_02_00_00000000_00000000_00000000_0_00_00000000_1_0_0_02_12345678
16_0_0_0_00_00_03_00_00000000_00000000_00000000_0_00_00000000_1_0_0_03_9abcdef0

// File: src.f
logic/exePkg.sv
logic/idExeReg.sv
logic/forwardUnit.sv
logic/alu.sv
logic/mulDiv.sv
logic/hiLo.sv
logic/exeMemReg.sv
logic/exeTop.sv
test/exeTb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - logic/exePkg.sv
  - logic/idExeReg.sv
  - logic/forwardUnit.sv
  - logic/alu.sv
  - logic/mulDiv.sv
  - logic/hiLo.sv
  - logic/exeMemReg.sv
  - logic/exeTop.sv
  - target: test
    files:
      - test/exeTb.sv

// File: test/exeTb.sv
// execute stage testbench
`timescale 1ns/1ns

module exeTb;
    import exePkg::*;

    localparam int NUM_PAT    = 41;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYC    = 10;
    localparam int RES_LAT    = 3;  // drive edge, ID/EX load, EX/MEM load
    localparam int LIMIT_CYC  = NUM_PAT * (MD_ITERS + 8) + RST_CYC;

    typedef struct packed {
        logic [7:0]  op;
        logic [3:0]  useImm;
        logic [3:0]  noGap;
        logic [3:0]  doFlush;
        logic [7:0]  rs;
        logic [7:0]  rt;
        logic [7:0]  dst;
        logic [7:0]  shamt;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] imm;
        logic [3:0]  wbWr;
        logic [7:0]  wbDst;
        logic [31:0] wbData;
        logic [3:0]  expWr;
        logic [3:0]  expTaken;
        logic [3:0]  expOvf;
        logic [7:0]  expDst;
        logic [31:0] expData;
    } patRec_t;

    localparam int PAT_W = $bits(patRec_t);

    logic                  clk;
    logic                  rst;
    logic                  issue;
    exeOp_t                op;
    logic [DATA_W-1:0]     srcA;
    logic [DATA_W-1:0]     srcB;
    logic [REG_IDX_W-1:0]  rsIdx;
    logic [REG_IDX_W-1:0]  rtIdx;
    logic [REG_IDX_W-1:0]  dstIdx;
    logic [DATA_W-1:0]     imm;
    logic                  useImm;
    logic [SHAMT_W-1:0]    shiftImm;
    logic                  flush;
    logic                  wbWr;
    logic [REG_IDX_W-1:0]  wbDst;
    logic [DATA_W-1:0]     wbData;
    logic                  stall;
    logic                  resValid;
    logic                  resWr;
    logic [REG_IDX_W-1:0]  resDst;
    logic [DATA_W-1:0]     resData;
    logic                  branchTaken;
    logic                  overflowExc;

    logic [PAT_W-1:0]  patMem [NUM_PAT];
    int                issueCyc [NUM_PAT];
    int                stallCyc [NUM_PAT];  // cycles each item held the stage
    int                pendQ [$];  // pattern numbers awaiting a result
    int                cycleCnt = 0;
    int                checkCount = 0;
    int                errCount = 0;
    int unsigned       lcgState = 90069;

    exeTop dut_i (
        .clk, .rst, .issue, .op, .srcA, .srcB, .rsIdx, .rtIdx, .dstIdx,
        .imm, .useImm, .shiftImm, .flush, .wbWr, .wbDst, .wbData,
        .stall, .resValid, .resWr, .resDst, .resData, .branchTaken, .overflowExc
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;
    endfunction

    function automatic logic variableLatency(exeOp_t o);
        return o inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    endfunction

    task automatic checkVal(string name, logic [31:0] expVal, logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            $display("ERR %0t ns %s expected %h got %h", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic driveInstr(int idx);
        patRec_t p;
        p = patMem[idx];
        issue    <= 1'b1;
        op       <= exeOp_t'(p.op[4:0]);
        srcA     <= p.srcA;
        srcB     <= p.srcB;
        imm      <= p.imm;
        rsIdx    <= p.rs[4:0];
        rtIdx    <= p.rt[4:0];
        dstIdx   <= p.dst[4:0];
        useImm   <= p.useImm[0];
        shiftImm <= p.shamt[4:0];
        issueCyc[idx] = cycleCnt;
        if (p.doFlush[0] == 1'b0)
            pendQ.push_back(idx);  // an aborted divide leaves nothing
    endtask

    task automatic driveWb(int idx);
        patRec_t p;
        p = patMem[idx];
        wbWr   <= p.wbWr[0];
        wbDst  <= p.wbDst[4:0];
        wbData <= p.wbData;
    endtask

    // let the item in EX move on, then idle a few cycles
    task automatic leaveEx(int idx);
        patRec_t p;
        exeOp_t  pOp;
        int      gap;
        p = patMem[idx];
        pOp = exeOp_t'(p.op[4:0]);
        gap = nextRand() % 4;
        if (p.doFlush[0]) begin
            repeat (4) @(posedge clk);
            flush <= 1'b1;  // mid-divide
            @(posedge clk);
            flush <= 1'b0;
            $display("test %0d %s flushed while busy", idx, pOp.name());
        end
        @(negedge clk);
        while (stall) begin
            stallCyc[idx]++;
            @(negedge clk);
        end
        repeat (gap) begin
            @(posedge clk);
            wbWr <= 1'b0;
        end
        @(posedge clk);
        wbWr <= 1'b0;
    endtask

    task automatic checkResult();
        patRec_t p;
        exeOp_t  pOp;
        int      idx;
        int      errBefore;
        if (pendQ.size() == 0) begin
            $display("a result appeared at %0t ns with no instruction outstanding", $time);
            errCount++;
        end else begin
            idx = pendQ.pop_front();
            p = patMem[idx];
            pOp = exeOp_t'(p.op[4:0]);
            errBefore = errCount;
            checkVal("resWr", p.expWr, resWr);
            checkVal("branchTaken", p.expTaken, branchTaken);
            checkVal("overflowExc", p.expOvf, overflowExc);
            if (p.expWr[0]) begin
                checkVal("resDst", p.expDst, resDst);
                checkVal("resData", p.expData, resData);
            end
            if (!variableLatency(pOp))
                checkVal("latency", RES_LAT, cycleCnt - issueCyc[idx]);
            checkVal("stall cycles", variableLatency(pOp) ? MD_ITERS : 0, stallCyc[idx]);
            $display("test %0d %s %s", idx, pOp.name(), (errCount == errBefore) ? "ok" : "mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (!rst && resValid === 1'b1)
            checkResult();
    end

    initial begin
        patRec_t cur;
        patRec_t prev;
        rst      = 1'b1;
        issue    = 1'b0;
        op       = OP_NOP;
        srcA     = '0;
        srcB     = '0;
        imm      = '0;
        rsIdx    = '0;
        rtIdx    = '0;
        dstIdx   = '0;
        useImm   = 1'b0;
        shiftImm = '0;
        flush    = 1'b0;
        wbWr     = 1'b0;
        wbDst    = '0;
        wbData   = '0;
        $readmemh("test/exePatterns.txt", patMem);
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("stall", 1'b0, stall);  // state straight out of reset
        checkVal("resValid", 1'b0, resValid);
        checkVal("resWr", 1'b0, resWr);
        checkVal("branchTaken", 1'b0, branchTaken);
        checkVal("overflowExc", 1'b0, overflowExc);
        while (stall) @(negedge clk);
        @(posedge clk);
        driveInstr(0);
        for (int i = 1; i < NUM_PAT; i++) begin
            cur = patMem[i];
            prev = patMem[i - 1];
            @(posedge clk);
            driveWb(i - 1);  // previous item is in EX from here
            if (!(cur.noGap[0] && !variableLatency(exeOp_t'(prev.op[4:0])))) begin
                issue <= 1'b0;
                leaveEx(i - 1);
            end
            driveInstr(i);
        end
        @(posedge clk);
        driveWb(NUM_PAT - 1);
        issue <= 1'b0;
        leaveEx(NUM_PAT - 1);
        while (pendQ.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray result
        $display("%0d tests, %0d checks, %0d errors", NUM_PAT, checkCount, errCount);
        if (errCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        #(LIMIT_CYC * CLK_PERIOD);
        $display("run timed out after %0d cycles with %0d results still outstanding",
                 LIMIT_CYC, pendQ.size());
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: logic/exeTop.sv
// execute stage top
`timescale 1ns/1ns

module exeTop (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue,
    input  exePkg::exeOp_t                op,
    input  logic [exePkg::DATA_W-1:0]     srcA,
    input  logic [exePkg::DATA_W-1:0]     srcB,
    input  logic [exePkg::REG_IDX_W-1:0]  rsIdx,
    input  logic [exePkg::REG_IDX_W-1:0]  rtIdx,
    input  logic [exePkg::REG_IDX_W-1:0]  dstIdx,
    input  logic [exePkg::DATA_W-1:0]     imm,
    input  logic                          useImm,
    input  logic [exePkg::SHAMT_W-1:0]    shiftImm,
    input  logic                          flush,
    input  logic                          wbWr,
    input  logic [exePkg::REG_IDX_W-1:0]  wbDst,
    input  logic [exePkg::DATA_W-1:0]     wbData,
    output logic                          stall,
    output logic                          resValid,
    output logic                          resWr,
    output logic [exePkg::REG_IDX_W-1:0]  resDst,
    output logic [exePkg::DATA_W-1:0]     resData,
    output logic                          branchTaken,
    output logic                          overflowExc
);
    import exePkg::*;

    exeOp_t                exOp;
    logic                  exValid;
    logic [DATA_W-1:0]     exA;
    logic [DATA_W-1:0]     exB;
    logic [DATA_W-1:0]     exImm;
    logic [REG_IDX_W-1:0]  exRs;
    logic [REG_IDX_W-1:0]  exRt;
    logic [REG_IDX_W-1:0]  exDst;
    logic                  exUseImm;
    logic [SHAMT_W-1:0]    exShift;
    logic [DATA_W-1:0]     opA;
    logic [DATA_W-1:0]     opB;
    logic [DATA_W-1:0]     aluA;
    logic [DATA_W-1:0]     aluB;
    logic [DATA_W-1:0]     aluOut;
    logic                  overflow;
    logic                  taken;
    logic                  done;
    logic [DATA_W-1:0]     mdHi;
    logic [DATA_W-1:0]     mdLo;
    logic [DATA_W-1:0]     hi;
    logic [DATA_W-1:0]     lo;

    idExeReg idExeReg_i (
        .clk, .rst, .flush, .issue, .stall,
        .op, .srcA, .srcB, .imm, .rsIdx, .rtIdx, .dstIdx, .useImm, .shiftImm,
        .exValid, .exOp, .exA, .exB, .exImm, .exRs, .exRt, .exDst, .exUseImm, .exShift
    );

    forwardUnit forwardUnit_i (
        .exRs, .exRt, .exA, .exB, .exImm, .exUseImm, .exShift, .exOp,
        .memWr   (resWr),   // EX/MEM bypass
        .memDst  (resDst),
        .memData (resData),
        .wbWr, .wbDst, .wbData,
        .opA, .opB, .aluA, .aluB
    );

    alu alu_i (
        .exOp, .aluA, .aluB, .aluOut, .overflow, .taken
    );

    mulDiv mulDiv_i (
        .clk, .rst, .flush, .exValid, .exOp, .opA, .opB,
        .busy (stall),
        .done, .mdHi, .mdLo
    );

    hiLo hiLo_i (
        .clk, .rst, .done, .exValid, .stall, .exOp, .opA, .mdHi, .mdLo, .hi, .lo
    );

    exeMemReg exeMemReg_i (
        .clk, .rst, .flush, .exValid,
        .busy (stall),
        .exOp, .exDst, .aluOut, .hi, .lo, .overflow, .taken,
        .resValid, .resWr, .branchTaken, .overflowExc, .resDst, .resData
    );

endmodule

// File: logic/exeMemReg.sv
// EX/MEM pipeline register
`timescale 1ns/1ns

module exeMemReg (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          exValid,
    input  logic                          busy,
    input  exePkg::exeOp_t                exOp,
    input  logic [exePkg::REG_IDX_W-1:0]  exDst,
    input  logic [exePkg::DATA_W-1:0]     aluOut,
    input  logic [exePkg::DATA_W-1:0]     hi,
    input  logic [exePkg::DATA_W-1:0]     lo,
    input  logic                          overflow,
    input  logic                          taken,
    output logic                          resValid,
    output logic                          resWr,
    output logic                          branchTaken,
    output logic                          overflowExc,
    output logic [exePkg::REG_IDX_W-1:0]  resDst,
    output logic [exePkg::DATA_W-1:0]     resData
);
    import exePkg::*;

    logic              take;
    logic [DATA_W-1:0] result;

    assign take = exValid && !busy;

    always_comb begin
        case (exOp)
            OP_MFHI: result = hi;
            OP_MFLO: result = lo;
            default: result = aluOut;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            resValid    <= 1'b0;
            resWr       <= 1'b0;
            branchTaken <= 1'b0;
            overflowExc <= 1'b0;
        end else begin
            resValid    <= take;
            resWr       <= take && writesGpr(exOp) && !overflow;  // trap kills the write
            branchTaken <= take && taken;
            overflowExc <= take && overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resDst  <= exDst;
            resData <= result;
        end
    end

    // flags only from branches and the trapping add or subtract
    flagsFromOp: assert property (@(posedge clk) disable iff (rst)
        take |-> (!taken || exOp inside {OP_BEQ, OP_BNE})
            && (!overflow || exOp inside {OP_ADD, OP_SUB}));

endmodule

// File: logic/hiLo.sv
// HI and LO registers
`timescale 1ns/1ns

module hiLo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        done,
    input  logic                        exValid,
    input  logic                        stall,
    input  exePkg::exeOp_t              exOp,
    input  logic [exePkg::DATA_W-1:0]   opA,
    input  logic [exePkg::DATA_W-1:0]   mdHi,
    input  logic [exePkg::DATA_W-1:0]   mdLo,
    output logic [exePkg::DATA_W-1:0]   hi,
    output logic [exePkg::DATA_W-1:0]   lo
);
    import exePkg::*;

    logic leaving;

    assign leaving = exValid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (done) begin
            hi <= mdHi;
            lo <= mdLo;
        end else if (leaving) begin
            if (exOp == OP_MTHI)
                hi <= opA;  // forwarded rs
            if (exOp == OP_MTLO)
                lo <= opA;
        end
    end

endmodule

// File: logic/mulDiv.sv
// iterative multiply and divide unit
`timescale 1ns/1ns

module mulDiv (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        exValid,
    input  exePkg::exeOp_t              exOp,
    input  logic [exePkg::DATA_W-1:0]   opA,
    input  logic [exePkg::DATA_W-1:0]   opB,
    output logic                        busy,
    output logic                        done,
    output logic [exePkg::DATA_W-1:0]   mdHi,
    output logic [exePkg::DATA_W-1:0]   mdLo
);
    import exePkg::*;

    typedef enum logic {MD_IDLE, MD_RUN} mdState_t;

    mdState_t                        state;
    logic [$clog2(MD_ITERS+1)-1:0]   cnt;
    logic                            start;
    logic                            finished;
    logic                            isDiv;
    logic                            isSigned;
    logic [DATA_W-1:0]               absA;
    logic [DATA_W-1:0]               absB;
    logic [DATA_W-1:0]               hiReg;
    logic [DATA_W-1:0]               loReg;
    logic [DATA_W-1:0]               opReg;
    logic                            divReg;
    logic                            negQ;
    logic                            negR;
    logic [DATA_W-1:0]               curHi;
    logic [DATA_W-1:0]               curLo;
    logic [DATA_W-1:0]               curOp;
    logic                            curDiv;
    logic [DATA_W:0]                 addSum;
    logic [DATA_W:0]                 remShift;
    logic [DATA_W:0]                 remDiff;
    logic [DATA_W-1:0]               nextHi;
    logic [DATA_W-1:0]               nextLo;
    logic [2*DATA_W-1:0]             prod;

    assign isDiv    = exOp inside {OP_DIV, OP_DIVU};
    assign isSigned = exOp inside {OP_MULT, OP_DIV};
    assign absA     = (isSigned && opA[DATA_W-1]) ? -opA : opA;
    assign absB     = (isSigned && opB[DATA_W-1]) ? -opB : opB;

    assign start    = (state == MD_IDLE) && exValid && isMulDiv(exOp);
    assign finished = (state == MD_RUN) && (cnt == MD_ITERS);
    assign busy     = start || ((state == MD_RUN) && !finished);
    assign done     = finished && !flush;  // flush on the last edge still aborts

    // first step runs straight off the operands
    assign curHi  = start ? '0 : hiReg;
    assign curLo  = start ? absA : loReg;
    assign curOp  = start ? absB : opReg;
    assign curDiv = start ? isDiv : divReg;

    assign addSum   = {1'b0, curHi} + (curLo[0] ? {1'b0, curOp} : '0);
    assign remShift = {curHi, curLo[DATA_W-1]};
    assign remDiff  = remShift - {1'b0, curOp};

    always_comb begin
        if (!curDiv) begin
            {nextHi, nextLo} = {addSum, curLo[DATA_W-1:1]};  // shift-add
        end else if (remShift >= {1'b0, curOp}) begin
            nextHi = remDiff[DATA_W-1:0];
            nextLo = {curLo[DATA_W-2:0], 1'b1};
        end else begin
            nextHi = remShift[DATA_W-1:0];  // restore
            nextLo = {curLo[DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= MD_IDLE;
            cnt   <= '0;
        end else if (start) begin
            state <= MD_RUN;
            cnt   <= 1;
        end else if (finished) begin
            state <= MD_IDLE;
        end else if (state == MD_RUN) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            hiReg <= nextHi;
            loReg <= nextLo;
        end
        if (start) begin
            opReg  <= absB;
            divReg <= isDiv;
            negQ   <= isSigned && (opA[DATA_W-1] ^ opB[DATA_W-1]) && (!isDiv || opB != '0);
            negR   <= isSigned && isDiv && opA[DATA_W-1];  // remainder takes dividend sign
        end
    end

    assign prod = negQ ? -{hiReg, loReg} : {hiReg, loReg};
    assign mdHi = divReg ? (negR ? -hiReg : hiReg) : prod[2*DATA_W-1:DATA_W];
    assign mdLo = divReg ? (negQ ? -loReg : loReg) : prod[DATA_W-1:0];

    // the finished item is still held in EX
    doneWithHeldItem: assert property (@(posedge clk) disable iff (rst)
        done |-> exValid && isMulDiv(exOp));

endmodule

// File: logic/alu.sv
// single-cycle integer ALU
`timescale 1ns/1ns

module alu (
    input  exePkg::exeOp_t              exOp,
    input  logic [exePkg::DATA_W-1:0]   aluA,
    input  logic [exePkg::DATA_W-1:0]   aluB,
    output logic [exePkg::DATA_W-1:0]   aluOut,
    output logic                        overflow,
    output logic                        taken
);
    import exePkg::*;

    logic [DATA_W-1:0]  sum;
    logic [DATA_W-1:0]  diff;
    logic [SHAMT_W-1:0] shamt;
    logic               signA;
    logic               signB;

    assign sum   = aluA + aluB;
    assign diff  = aluA - aluB;
    assign shamt = aluA[SHAMT_W-1:0];
    assign signA = aluA[DATA_W-1];
    assign signB = aluB[DATA_W-1];

    always_comb begin
        case (exOp)
            OP_ADD, OP_ADDU: aluOut = sum;
            OP_SUB, OP_SUBU: aluOut = diff;
            OP_AND:          aluOut = aluA & aluB;
            OP_OR:           aluOut = aluA | aluB;
            OP_XOR:          aluOut = aluA ^ aluB;
            OP_NOR:          aluOut = ~(aluA | aluB);
            OP_SLT:          aluOut = DATA_W'($signed(aluA) < $signed(aluB));
            OP_SLTU:         aluOut = DATA_W'(aluA < aluB);
            OP_SLL:          aluOut = aluB << shamt;
            OP_SRL:          aluOut = aluB >> shamt;
            OP_SRA:          aluOut = $signed(aluB) >>> shamt;
            OP_LUI:          aluOut = {aluB[15:0], 16'h0000};
            OP_MTHI, OP_MTLO: aluOut = aluA;  // value headed for HI/LO
            default:         aluOut = '0;
        endcase
    end

    // signed overflow only for the trapping forms
    always_comb begin
        case (exOp)
            OP_ADD:  overflow = (signA == signB) && (sum[DATA_W-1] != signA);
            OP_SUB:  overflow = (signA != signB) && (diff[DATA_W-1] != signA);
            default: overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (exOp)
            OP_BEQ:  taken = (aluA == aluB);
            OP_BNE:  taken = (aluA != aluB);
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: logic/forwardUnit.sv
// operand forwarding and ALU source select
`timescale 1ns/1ns

module forwardUnit (
    input  logic [exePkg::REG_IDX_W-1:0]  exRs,
    input  logic [exePkg::REG_IDX_W-1:0]  exRt,
    input  logic [exePkg::DATA_W-1:0]     exA,
    input  logic [exePkg::DATA_W-1:0]     exB,
    input  logic [exePkg::DATA_W-1:0]     exImm,
    input  logic                          exUseImm,
    input  logic [exePkg::SHAMT_W-1:0]    exShift,
    input  exePkg::exeOp_t                exOp,
    input  logic                          memWr,
    input  logic                          wbWr,
    input  logic [exePkg::REG_IDX_W-1:0]  memDst,
    input  logic [exePkg::REG_IDX_W-1:0]  wbDst,
    input  logic [exePkg::DATA_W-1:0]     memData,
    input  logic [exePkg::DATA_W-1:0]     wbData,
    output logic [exePkg::DATA_W-1:0]     opA,
    output logic [exePkg::DATA_W-1:0]     opB,
    output logic [exePkg::DATA_W-1:0]     aluA,
    output logic [exePkg::DATA_W-1:0]     aluB
);
    import exePkg::*;

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;
    logic isShift;

    // r0 is hardwired, never bypassed
    assign memHitA = memWr && (memDst == exRs) && (exRs != '0);
    assign memHitB = memWr && (memDst == exRt) && (exRt != '0);
    assign wbHitA  = wbWr && (wbDst == exRs) && (exRs != '0);
    assign wbHitB  = wbWr && (wbDst == exRt) && (exRt != '0);

    assign opA = memHitA ? memData : (wbHitA ? wbData : exA);  // EX/MEM is younger
    assign opB = memHitB ? memData : (wbHitB ? wbData : exB);

    assign isShift = exOp inside {OP_SLL, OP_SRL, OP_SRA};

    assign aluA = isShift ? DATA_W'(exShift) : opA;
    assign aluB = exUseImm ? exImm : opB;

endmodule

// File: logic/idExeReg.sv
// ID/EX pipeline register
`timescale 1ns/1ns

module idExeReg (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          issue,
    input  logic                          stall,
    input  exePkg::exeOp_t                op,
    input  logic [exePkg::DATA_W-1:0]     srcA,
    input  logic [exePkg::DATA_W-1:0]     srcB,
    input  logic [exePkg::DATA_W-1:0]     imm,
    input  logic [exePkg::REG_IDX_W-1:0]  rsIdx,
    input  logic [exePkg::REG_IDX_W-1:0]  rtIdx,
    input  logic [exePkg::REG_IDX_W-1:0]  dstIdx,
    input  logic                          useImm,
    input  logic [exePkg::SHAMT_W-1:0]    shiftImm,
    output logic                          exValid,
    output exePkg::exeOp_t                exOp,
    output logic [exePkg::DATA_W-1:0]     exA,
    output logic [exePkg::DATA_W-1:0]     exB,
    output logic [exePkg::DATA_W-1:0]     exImm,
    output logic [exePkg::REG_IDX_W-1:0]  exRs,
    output logic [exePkg::REG_IDX_W-1:0]  exRt,
    output logic [exePkg::REG_IDX_W-1:0]  exDst,
    output logic                          exUseImm,
    output logic [exePkg::SHAMT_W-1:0]    exShift
);
    import exePkg::*;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            exValid <= 1'b0;
            exOp    <= OP_NOP;
        end else if (!stall) begin
            exValid <= issue;
            exOp    <= issue ? op : OP_NOP;  // bubble when nothing issued
        end
    end

    always_ff @(posedge clk) begin
        if (issue && !stall) begin
            exA      <= srcA;
            exB      <= srcB;
            exImm    <= imm;
            exRs     <= rsIdx;
            exRt     <= rtIdx;
            exDst    <= dstIdx;
            exUseImm <= useImm;
            exShift  <= shiftImm;
        end
    end

    noIssueOnStall: assert property (@(posedge clk) disable iff (rst) stall |-> !issue)
        else $error("issue raised while the stage is stalled");

    // only a held multiply or divide may stall the stage
    stallOnMulDiv: assert property (@(posedge clk) disable iff (rst)
        stall |-> exValid && isMulDiv(exOp));

    legalOp: assert property (@(posedge clk) disable iff (rst) exOp <= OP_MTLO);

endmodule

// File: logic/exePkg.sv
// execute stage shared definitions
package exePkg;

    localparam int DATA_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int MD_ITERS  = 32;  // one quotient or product bit per cycle

    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADD   = 5'd1,
        OP_ADDU  = 5'd2,
        OP_SUB   = 5'd3,
        OP_SUBU  = 5'd4,
        OP_AND   = 5'd5,
        OP_OR    = 5'd6,
        OP_XOR   = 5'd7,
        OP_NOR   = 5'd8,
        OP_SLT   = 5'd9,
        OP_SLTU  = 5'd10,
        OP_SLL   = 5'd11,
        OP_SRL   = 5'd12,
        OP_SRA   = 5'd13,
        OP_LUI   = 5'd14,
        OP_BEQ   = 5'd15,
        OP_BNE   = 5'd16,
        OP_MULT  = 5'd17,
        OP_MULTU = 5'd18,
        OP_DIV   = 5'd19,
        OP_DIVU  = 5'd20,
        OP_MFHI  = 5'd21,
        OP_MFLO  = 5'd22,
        OP_MTHI  = 5'd23,
        OP_MTLO  = 5'd24   // highest legal code
    } exeOp_t;

    function automatic logic isMulDiv(exeOp_t op);
        return op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    endfunction

    // ops that leave a value for the register file
    function automatic logic writesGpr(exeOp_t op);
        return op inside {
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_AND, OP_OR, OP_XOR, OP_NOR,
            OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI,
            OP_MFHI, OP_MFLO
        };
    endfunction

endpackage
